// ==== design/timing_config.svh ====
`ifndef TIMING_CONFIG_SVH
`define TIMING_CONFIG_SVH

`define TIMING_USEC_DIV      50     // mclk cycles per microsecond (50 MHz)
`define TIMING_NUM_CHN       2      // trigger channels
`define TIMING_USEC_MAX      999999 // last microsecond of a second

// register addresses
`define TIMING_REG_SET_USEC  0      // microseconds shadow
`define TIMING_REG_SET_SEC   1      // seconds, applies shadow too
`define TIMING_REG_PERIOD    2      // trigger period
`define TIMING_REG_MODE      3      // bit 0 triggered mode, bits 2:1 channel enables

`endif

// ==== design/timing_pkg.sv ====
package timing_pkg;

    typedef logic [31:0] sec_t;      // seconds count
    typedef logic [19:0] usec_t;     // microseconds in the second, 0..999999
    typedef logic [7:0]  ts_byte_t;  // one byte of a serialized timestamp

    typedef logic [3:0]  reg_addr_t; // register write address
    typedef logic [31:0] reg_data_t; // register write data

    typedef logic [31:0] period_t;   // trigger period, mclk cycles

    // timestamp serializer
    typedef enum logic [1:0] {
        SER_IDLE = 2'd0,             // waiting for snap
        SER_PRE  = 2'd1,             // pre-strobe cycle
        SER_SEND = 2'd2              // eight data bytes
    } ser_state_t;

endpackage

// ==== design/timing_cfg_if.sv ====
`timescale 1ns/1ps
`include "timing_config.svh"

interface timing_cfg_if;
    import timing_pkg::*;

    logic                       set_stb;     // one-cycle rtc load pulse
    sec_t                       set_sec;     // seconds to load
    usec_t                      set_usec;    // microseconds to load
    period_t                    trig_period; // trigger period in mclk cycles
    logic                       trig_mode;   // triggered mode on
    logic [`TIMING_NUM_CHN-1:0] chn_en;      // per-channel trigger enable

    modport regs (
        output set_stb, set_sec, set_usec,
        output trig_period, trig_mode, chn_en
    );

    modport rtc (
        input set_stb, set_sec, set_usec
    );

    modport trig (
        input trig_period, trig_mode, chn_en
    );

endinterface

// ==== design/timing_regs.sv ====
`timescale 1ns/1ps
`include "timing_config.svh"

module timing_regs (
    input  logic                  mclk,
    input  logic                  rst_n,
    input  timing_pkg::reg_addr_t cmd_addr,       // write address
    input  timing_pkg::reg_data_t cmd_data,       // write data
    input  logic                  cmd_stb,        // one-cycle write strobe
    timing_cfg_if.regs            cfg,
    output logic                  triggered_mode  // mode bit to pins
);
    import timing_pkg::*;

    usec_t                      usec_shadow;  // waits for the seconds write
    sec_t                       sec_reg;
    period_t                    period_reg;
    logic                       mode_reg;
    logic [`TIMING_NUM_CHN-1:0] chn_en_reg;
    logic                       set_stb_r;    // delayed SET_SEC write
    logic                       wr_usec;
    logic                       wr_sec;
    logic                       wr_period;
    logic                       wr_mode;
    usec_t                      usec_clamped;

    assign wr_usec   = cmd_stb && (cmd_addr == reg_addr_t'(`TIMING_REG_SET_USEC));
    assign wr_sec    = cmd_stb && (cmd_addr == reg_addr_t'(`TIMING_REG_SET_SEC));
    assign wr_period = cmd_stb && (cmd_addr == reg_addr_t'(`TIMING_REG_PERIOD));
    assign wr_mode   = cmd_stb && (cmd_addr == reg_addr_t'(`TIMING_REG_MODE));

    // saturate out-of-range microseconds
    assign usec_clamped = (cmd_data > reg_data_t'(`TIMING_USEC_MAX)) ?
                          usec_t'(`TIMING_USEC_MAX) : usec_t'(cmd_data);

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            usec_shadow <= '0;
            sec_reg     <= '0;
            period_reg  <= '0;
            mode_reg    <= 1'b0;
            chn_en_reg  <= '0;
            set_stb_r   <= 1'b0;
        end else begin
            set_stb_r <= wr_sec;                                    // high the cycle after write
            if (wr_usec)   usec_shadow <= usec_clamped;
            if (wr_sec)    sec_reg     <= cmd_data;
            if (wr_period) period_reg  <= cmd_data;
            if (wr_mode) begin
                mode_reg   <= cmd_data[0];
                chn_en_reg <= cmd_data[`TIMING_NUM_CHN:1];          // bits 2:1
            end
        end
    end

    assign cfg.set_stb     = set_stb_r;
    assign cfg.set_sec     = sec_reg;
    assign cfg.set_usec    = usec_shadow;                           // loaded with the seconds
    assign cfg.trig_period = period_reg;
    assign cfg.trig_mode   = mode_reg;
    assign cfg.chn_en      = chn_en_reg;
    assign triggered_mode  = mode_reg;

endmodule

// ==== design/rtc_counter.sv ====
`timescale 1ns/1ps
`include "timing_config.svh"

module rtc_counter #(
    parameter int USEC_DIV = `TIMING_USEC_DIV  // mclk cycles per microsecond
) (
    input  logic              mclk,
    input  logic              rst_n,
    timing_cfg_if.rtc         cfg,
    output timing_pkg::sec_t  live_sec,   // current seconds
    output timing_pkg::usec_t live_usec   // current microseconds
);
    import timing_pkg::*;

    localparam int PRE_W = $clog2(USEC_DIV + 1);

    logic [PRE_W-1:0] pre_cnt;    // counts mclk within one microsecond
    logic             usec_tick;  // last prescaler cycle
    logic             usec_wrap;  // second boundary

    assign usec_tick = (pre_cnt == PRE_W'(USEC_DIV - 1));
    assign usec_wrap = (live_usec == usec_t'(`TIMING_USEC_MAX));

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            pre_cnt   <= '0;
            live_sec  <= '0;
            live_usec <= '0;
        end else if (cfg.set_stb) begin
            pre_cnt   <= '0;              // restart prescaler on load
            live_sec  <= cfg.set_sec;
            live_usec <= cfg.set_usec;
        end else if (usec_tick) begin
            pre_cnt <= '0;
            if (usec_wrap) begin
                live_usec <= '0;          // carry into seconds
                live_sec  <= live_sec + sec_t'(1);
            end else begin
                live_usec <= live_usec + usec_t'(1);
            end
        end else begin
            pre_cnt <= pre_cnt + PRE_W'(1);
        end
    end

endmodule

// ==== design/trig_gen.sv ====
`timescale 1ns/1ps
`include "timing_config.svh"

module trig_gen (
    input  logic                       mclk,
    input  logic                       rst_n,
    timing_cfg_if.trig                 cfg,
    output logic [`TIMING_NUM_CHN-1:0] trig   // one-cycle per-channel pulses
);
    import timing_pkg::*;

    period_t                    cnt;           // cycles into the current period
    period_t                    cnt_eff;       // count seen this cycle
    period_t                    period_q;      // last cycle's config, for restart
    logic                       mode_q;
    logic [`TIMING_NUM_CHN-1:0] chn_en_q;
    logic                       run;
    logic                       restart;
    logic                       period_pulse;

    assign run     = cfg.trig_mode && (cfg.trig_period != '0);
    assign restart = (cfg.trig_period != period_q) || (cfg.trig_mode != mode_q) ||
                     (cfg.chn_en != chn_en_q);           // a MODE or PERIOD write
    assign cnt_eff = restart ? '0 : cnt;                 // new config counts from zero
    assign period_pulse = run && (cnt_eff == cfg.trig_period - period_t'(1));

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            period_q <= '0;
            mode_q   <= 1'b0;
            chn_en_q <= '0;
            trig     <= '0;
        end else begin
            period_q <= cfg.trig_period;
            mode_q   <= cfg.trig_mode;
            chn_en_q <= cfg.chn_en;
            if (!run || period_pulse)
                cnt <= '0;                               // held while stopped
            else
                cnt <= cnt_eff + period_t'(1);
            trig <= period_pulse ? cfg.chn_en : '0;      // fan out through enables
        end
    end

endmodule

// ==== design/ts_snapshot.sv ====
`timescale 1ns/1ps

module ts_snapshot (
    input  logic                 mclk,
    input  logic                 rst_n,
    input  timing_pkg::sec_t     sec,      // live seconds
    input  timing_pkg::usec_t    usec,     // live microseconds
    input  logic                 snap,     // take a snapshot
    output logic                 pre_stb,  // one cycle before the first byte
    output timing_pkg::ts_byte_t ts_data   // serialized timestamp
);
    import timing_pkg::*;

    ser_state_t  state;
    logic [2:0]  byte_cnt;  // byte being shown
    logic [63:0] img;       // {usec, sec}, shifted right per byte
    logic        take;

    assign take = (state == SER_IDLE) && snap;  // snaps while busy are dropped

    always_ff @(posedge mclk) begin
        if (take)
            img <= {32'(usec), sec};            // seconds go out first
        else if (state != SER_IDLE)
            img <= {8'h00, img[63:8]};
    end

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= SER_IDLE;
            byte_cnt <= '0;
            pre_stb  <= 1'b0;
            ts_data  <= '0;
        end else begin
            pre_stb <= take;
            case (state)
                SER_IDLE: begin
                    if (take) state <= SER_PRE;
                end
                SER_PRE: begin
                    ts_data  <= img[7:0];       // sec byte 0
                    byte_cnt <= '0;
                    state    <= SER_SEND;
                end
                SER_SEND: begin
                    if (byte_cnt == 3'd7) begin
                        ts_data <= '0;          // quiet between messages
                        state   <= SER_IDLE;
                    end else begin
                        ts_data  <= img[7:0];
                        byte_cnt <= byte_cnt + 3'd1;
                    end
                end
                default: state <= SER_IDLE;
            endcase
        end
    end

endmodule

// ==== design/timing_top.sv ====
`timescale 1ns/1ps
`include "timing_config.svh"

module timing_top #(
    parameter int USEC_DIV = `TIMING_USEC_DIV       // mclk cycles per microsecond
) (
    input  logic                       mclk,
    input  logic                       rst_n,
    input  timing_pkg::reg_addr_t      cmd_addr,
    input  timing_pkg::reg_data_t      cmd_data,
    input  logic                       cmd_stb,
    input  logic                       ts_logger_snap,  // logger snapshot request
    output logic                       triggered_mode,
    output logic [`TIMING_NUM_CHN-1:0] trig_chn,        // one-cycle triggers
    output logic                       ts_stb_chn0,
    output timing_pkg::ts_byte_t       ts_data_chn0,
    output logic                       ts_stb_chn1,
    output timing_pkg::ts_byte_t       ts_data_chn1,
    output logic                       ts_logger_stb,
    output timing_pkg::ts_byte_t       ts_logger_data,
    output timing_pkg::sec_t           live_sec,
    output timing_pkg::usec_t          live_usec
);

    timing_cfg_if cfg_if ();                            // regs to rtc and triggers

    timing_regs regs_i (
        .mclk           (mclk),
        .rst_n          (rst_n),
        .cmd_addr       (cmd_addr),
        .cmd_data       (cmd_data),
        .cmd_stb        (cmd_stb),
        .cfg            (cfg_if.regs),
        .triggered_mode (triggered_mode)
    );

    rtc_counter #(.USEC_DIV(USEC_DIV)) rtc_i (
        .mclk      (mclk),
        .rst_n     (rst_n),
        .cfg       (cfg_if.rtc),
        .live_sec  (live_sec),
        .live_usec (live_usec)
    );

    trig_gen trig_gen_i (
        .mclk  (mclk),
        .rst_n (rst_n),
        .cfg   (cfg_if.trig),
        .trig  (trig_chn)
    );

    ts_snapshot snap_chn0_i (
        .mclk    (mclk),        .rst_n   (rst_n),
        .sec     (live_sec),    .usec    (live_usec),
        .snap    (trig_chn[0]), // stamped by its own trigger
        .pre_stb (ts_stb_chn0), .ts_data (ts_data_chn0)
    );

    ts_snapshot snap_chn1_i (
        .mclk    (mclk),        .rst_n   (rst_n),
        .sec     (live_sec),    .usec    (live_usec),
        .snap    (trig_chn[1]),
        .pre_stb (ts_stb_chn1), .ts_data (ts_data_chn1)
    );

    ts_snapshot snap_logger_i (
        .mclk    (mclk),          .rst_n   (rst_n),
        .sec     (live_sec),      .usec    (live_usec),
        .snap    (ts_logger_snap),
        .pre_stb (ts_logger_stb), .ts_data (ts_logger_data)
    );

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic mclk,
    output logic rst_n
);

    initial begin
        mclk = 1'b0;
        forever #10 mclk = ~mclk;          // 20 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge mclk);       // ten cycles in reset
        @(negedge mclk);
        rst_n = 1'b1;                      // release away from the rising edge
    end

endmodule

// ==== testbench/timing_props.sv ====
`timescale 1ns/1ps
`include "timing_config.svh"

module timing_props (
    input logic                       mclk,
    input logic                       rst_n,
    input logic                       pre_stb,    // serializer strobe
    input logic [`TIMING_NUM_CHN-1:0] trig,       // trigger pulses
    input logic                       trig_mode   // triggered mode from config
);

    logic [7:0] stb_hist;  // strobes of the last eight cycles

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n)
            stb_hist <= '0;
        else
            stb_hist <= {stb_hist[6:0], pre_stb};
    end

    // eight data bytes follow each strobe
    a_stb_window: assert property (@(posedge mclk) disable iff (!rst_n)
        pre_stb |-> (stb_hist == '0))
        else $error("strobe inside a message window");

    a_trig_width: assert property (@(posedge mclk) disable iff (!rst_n)
        (|trig) |=> (trig == '0))
        else $error("trigger pulse longer than one cycle");

    a_trig_mode: assert property (@(posedge mclk) disable iff (!rst_n)
        (|trig) |-> $past(trig_mode))  // pulse registered one cycle after the mode bit
        else $error("trigger while triggered mode is off");

endmodule

bind ts_snapshot timing_props stb_props_i (
    .mclk(mclk), .rst_n(rst_n), .pre_stb(pre_stb), .trig('0), .trig_mode(1'b0)
);

bind trig_gen timing_props trig_props_i (
    .mclk(mclk), .rst_n(rst_n), .pre_stb(1'b0), .trig(trig), .trig_mode(cfg.trig_mode)
);

// ==== testbench/tb_timing.sv ====
`timescale 1ns/1ps
`include "timing_config.svh"

module tb_timing;
    import timing_pkg::*;

    localparam int TEST_CYCLES = 260;                 // all tests back to back
    localparam int CYCLE_LIMIT = TEST_CYCLES + 140;
    localparam int SRC_CHN1    = 1;
    localparam int SRC_LOGGER  = 2;

    logic                       mclk;
    logic                       rst_n;
    reg_addr_t                  cmd_addr;
    reg_data_t                  cmd_data;
    logic                       cmd_stb;
    logic                       ts_logger_snap;
    logic                       triggered_mode;
    logic [`TIMING_NUM_CHN-1:0] trig_chn;
    logic                       ts_stb_chn0;
    ts_byte_t                   ts_data_chn0;
    logic                       ts_stb_chn1;
    ts_byte_t                   ts_data_chn1;
    logic                       ts_logger_stb;
    ts_byte_t                   ts_logger_data;
    sec_t                       live_sec;
    usec_t                      live_usec;
    int                         errors = 0;
    int                         checks = 0;
    int                         cycles = 0;
    int                         chn0_hits = 0;   // channel 0 never enabled

    tb_clk_gen clk_gen_i (.mclk(mclk), .rst_n(rst_n));

    timing_top #(.USEC_DIV(4)) i_dut (.*);       // short microsecond for fast runs

    always @(posedge mclk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run did not complete within %0d cycles", CYCLE_LIMIT);
            report_counts();
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    always @(negedge mclk) begin
        if (rst_n && (trig_chn[0] || ts_stb_chn0))
            chn0_hits++;
    end

    task automatic report_counts();
        $display("errors: %0d of %0d checks", errors, checks);
    endtask

    task automatic check_sec(input string name, input sec_t got, input sec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_usec(input string name, input usec_t got, input usec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input ts_byte_t got, input ts_byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // seconds LSB first, then usec widened to a word
    function automatic ts_byte_t expected_byte(input sec_t s, input usec_t u, input int idx);
        if (idx < 4)
            return ts_byte_t'(s >> (8 * idx));
        return ts_byte_t'(32'(u) >> (8 * (idx - 4)));
    endfunction

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(negedge mclk);
        cmd_addr = addr;
        cmd_data = data;
        cmd_stb  = 1'b1;
        @(negedge mclk);
        cmd_stb  = 1'b0;                          // returns in cycle N+1
    endtask

    // strobe at S+1, bytes at S+2..S+9; resnap pulses the logger again at S+3
    task automatic read_message(input int src, input sec_t s, input usec_t u, input bit resnap);
        string stb_name;
        string data_name;
        stb_name  = (src == SRC_LOGGER) ? "ts_logger_stb" : "ts_stb_chn1";
        data_name = (src == SRC_LOGGER) ? "ts_logger_data" : "ts_data_chn1";
        for (int i = 0; i < 9; i++) begin
            @(negedge mclk);
            if (src == SRC_LOGGER)
                ts_logger_snap = resnap && (i == 2);
            check_bit(stb_name, (src == SRC_LOGGER) ? ts_logger_stb : ts_stb_chn1, i == 0);
            if (i > 0)
                check_byte(data_name, (src == SRC_LOGGER) ? ts_logger_data : ts_data_chn1,
                           expected_byte(s, u, i - 1));
        end
    endtask

    // cycles counted from the first cycle the new config is live
    task automatic wait_trig(input int limit, output bit found, output int waited);
        found  = 1'b0;
        waited = 0;
        while (!found && waited < limit) begin
            @(negedge mclk);
            waited++;
            found = (trig_chn != '0);
        end
    endtask

    task automatic test_reset();
        check_bit("triggered_mode", triggered_mode, 1'b0);
        check_bit("trig_chn[0]", trig_chn[0], 1'b0);
        check_bit("trig_chn[1]", trig_chn[1], 1'b0);
        check_bit("ts_stb_chn0", ts_stb_chn0, 1'b0);
        check_bit("ts_stb_chn1", ts_stb_chn1, 1'b0);
        check_bit("ts_logger_stb", ts_logger_stb, 1'b0);
        check_byte("ts_data_chn0", ts_data_chn0, 8'h00);
        check_byte("ts_data_chn1", ts_data_chn1, 8'h00);
        check_byte("ts_logger_data", ts_logger_data, 8'h00);
        check_sec("live_sec", live_sec, '0);
        check_usec("live_usec", live_usec, '0);
    endtask

    task automatic test_rtc_load();
        sec_t  s;
        usec_t u;
        int    k;
        s = $urandom();
        u = usec_t'($urandom_range(899999, 0));   // no second carry during the test
        k = 20 + $urandom_range(40, 0);
        write_reg(reg_addr_t'(`TIMING_REG_SET_USEC), reg_data_t'(u));
        write_reg(reg_addr_t'(`TIMING_REG_SET_SEC), s);
        @(negedge mclk);                          // N+2
        check_sec("live_sec", live_sec, s);
        check_usec("live_usec", live_usec, u);
        repeat (k) @(negedge mclk);
        check_sec("live_sec", live_sec, s);
        check_usec("live_usec", live_usec, u + usec_t'(k / 4));
    endtask

    task automatic test_usec_wrap();
        sec_t s;
        s = $urandom();
        write_reg(reg_addr_t'(`TIMING_REG_SET_USEC), 32'd999998);
        write_reg(reg_addr_t'(`TIMING_REG_SET_SEC), s);
        @(negedge mclk);
        repeat (8) @(negedge mclk);               // two microseconds later
        check_usec("live_usec", live_usec, '0);
        check_sec("live_sec", live_sec, s + sec_t'(1));
    endtask

    task automatic test_logger_snap();
        sec_t  s;
        usec_t u;
        @(negedge mclk);
        ts_logger_snap = 1'b1;
        s = live_sec;                             // time of the snap cycle
        u = live_usec;
        read_message(SRC_LOGGER, s, u, 1'b0);
    endtask

    task automatic test_triggers();
        sec_t  s;
        usec_t u;
        bit    found;
        int    waited;
        write_reg(reg_addr_t'(`TIMING_REG_PERIOD), 32'd20);
        write_reg(reg_addr_t'(`TIMING_REG_MODE), 32'h5);   // mode on, channel 1 only
        check_bit("triggered_mode", triggered_mode, 1'b1);
        wait_trig(40, found, waited);
        if (!found) begin
            errors++;
            $display("no trigger within 40 cycles of enabling triggered mode");
            return;
        end
        checks++;
        if (waited != 20) begin
            errors++;
            $display("first trigger came %0d cycles after the mode write instead of 20",
                     waited);
        end
        for (int p = 0; p < 3; p++) begin
            if (p > 0)
                @(negedge mclk);                  // T+20
            check_bit("trig_chn[1]", trig_chn[1], 1'b1);
            check_bit("trig_chn[0]", trig_chn[0], 1'b0);
            s = live_sec;
            u = live_usec;
            read_message(SRC_CHN1, s, u, 1'b0);
            repeat (10) begin
                @(negedge mclk);
                check_bit("trig_chn[1]", trig_chn[1], 1'b0);
            end
        end
        write_reg(reg_addr_t'(`TIMING_REG_MODE), 32'h4); // enable kept, mode off
        check_bit("triggered_mode", triggered_mode, 1'b0);
        repeat (50) begin
            @(negedge mclk);
            check_bit("trig_chn", |trig_chn, 1'b0);
        end
        check_bit("channel 0 activity", chn0_hits != 0, 1'b0);
    endtask

    task automatic test_busy_snap();
        sec_t  s;
        usec_t u;
        @(negedge mclk);
        ts_logger_snap = 1'b1;
        s = live_sec;
        u = live_usec;
        read_message(SRC_LOGGER, s, u, 1'b1);     // second snap lands at S+3
        repeat (3) begin
            @(negedge mclk);
            check_bit("ts_logger_stb", ts_logger_stb, 1'b0);
        end
    endtask

    initial begin
        cmd_addr       = '0;
        cmd_data       = '0;
        cmd_stb        = 1'b0;
        ts_logger_snap = 1'b0;
        void'($urandom(32'hf802_b7f3));
        @(posedge rst_n);
        @(negedge mclk);
        test_reset();
        test_rtc_load();
        test_usec_wrap();
        test_logger_snap();
        test_triggers();
        test_busy_snap();
        report_counts();
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+design
design/timing_pkg.sv
design/timing_cfg_if.sv
design/timing_regs.sv
design/rtc_counter.sv
design/trig_gen.sv
design/ts_snapshot.sv
design/timing_top.sv
testbench/tb_clk_gen.sv
testbench/timing_props.sv
testbench/tb_timing.sv

// ==== Makefile ====
TOP := tb_timing

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean
